// File: rv_decode_pkg.sv
package rv_decode_pkg;

    // ============================================================
    // widths with a meaning
    // ============================================================
    typedef logic [31:0] inst_t;
    typedef logic [31:0] pc_t;
    typedef logic [31:0] imm_t;
    typedef logic [4:0]  reg_idx_t;

    // ============================================================
    // decode enums
    // ============================================================
    // alu_pass forwards operand 2 unchanged (lui)
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_xor, alu_or,
        alu_and, alu_sll, alu_srl, alu_sra, alu_pass
    } alu_op_e;

    typedef enum logic {src1_rs1, src1_pc} src1_sel_e;

    typedef enum logic [1:0] {src2_rs2, src2_imm, src2_four} src2_sel_e;

    // encoding matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {mem_byte, mem_half, mem_word, mem_dword} mem_size_e;

    typedef enum logic [2:0] {
        cmp_none, cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_ltu, cmp_geu
    } cmp_e;

    typedef enum logic [1:0] {jump_none, jump_pc_imm, jump_rs1_imm} jump_e;

    typedef enum logic {fetch_idle, fetch_wait_ack} fetch_state_e;

    // ============================================================
    // major opcodes
    // ============================================================
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    // alu funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_JALR = 3'b000;
    localparam logic [2:0] F3_PRIV = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    localparam logic [11:0] EBREAK_FUNCT12 = 12'h001;

endpackage

// File: ifetch_wb.sv
`timescale 1ns/1ps

module ifetch_wb import rv_decode_pkg::*; #(
    parameter pc_t RESET_PC = '0
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    // wishbone classic, read only
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output pc_t   wb_adr_o,
    input  logic  wb_ack_i,
    input  inst_t wb_dat_i,
    // queue side
    input  logic  full_i,
    output logic  push_o,
    output inst_t push_inst_o,
    output pc_t   push_pc_o
);

    fetch_state_e state;
    pc_t          fetch_pc;

    // ============================================================
    // request fsm
    // ============================================================
    // one transfer in flight at most; cyc drops for a cycle after ack
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= fetch_idle;
            fetch_pc <= RESET_PC;
        end else begin
            case (state)
                fetch_idle: begin
                    if (!full_i) begin
                        state <= fetch_wait_ack;
                    end
                end
                fetch_wait_ack: begin
                    if (wb_ack_i) begin
                        state    <= fetch_idle;
                        fetch_pc <= fetch_pc + 32'd4;
                    end
                end
                default: begin
                    state <= fetch_idle;
                end
            endcase
        end
    end

    // bus outputs straight from registers, so adr holds until ack
    assign wb_cyc_o = (state == fetch_wait_ack);
    assign wb_stb_o = (state == fetch_wait_ack);
    assign wb_adr_o = fetch_pc;

    // push the word on the ack cycle
    assign push_o      = (state == fetch_wait_ack) && wb_ack_i;
    assign push_inst_o = wb_dat_i;
    assign push_pc_o   = fetch_pc;

endmodule

// File: inst_queue.sv
`timescale 1ns/1ps

module inst_queue import rv_decode_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  push_i,
    input  inst_t push_inst_i,
    input  pc_t   push_pc_i,
    input  logic  pop_i,
    output logic  full_o,
    output logic  empty_o,
    output inst_t head_inst_o,
    output pc_t   head_pc_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    inst_t            inst_mem [QUEUE_DEPTH];
    pc_t              pc_mem   [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    // storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            inst_mem[wr_ptr] <= push_inst_i;
            pc_mem[wr_ptr]   <= push_pc_i;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full_o  = (count == (PTR_W+1)'(QUEUE_DEPTH));
    assign empty_o = (count == '0);

    // first word fall through
    assign head_inst_o = inst_mem[rd_ptr];
    assign head_pc_o   = pc_mem[rd_ptr];

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import rv_decode_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // queue head
    input  logic      empty_i,
    input  inst_t     head_inst_i,
    input  pc_t       head_pc_i,
    output logic      pop_o,
    // decoded output, valid/ready
    input  logic      dec_ready_i,
    output logic      dec_valid_o,
    output pc_t       dec_pc_o,
    output reg_idx_t  dec_rd_o,
    output reg_idx_t  dec_rs1_o,
    output reg_idx_t  dec_rs2_o,
    output imm_t      dec_imm_o,
    output alu_op_e   dec_alu_op_o,
    output logic      dec_word_op_o,
    output src1_sel_e dec_src1_o,
    output src2_sel_e dec_src2_o,
    output logic      dec_write_gpr_o,
    output logic      dec_mem_read_o,
    output logic      dec_mem_write_o,
    output logic      dec_mem_unsigned_o,
    output mem_size_e dec_mem_size_o,
    output cmp_e      dec_cmp_o,
    output jump_e     dec_jump_o,
    output logic      dec_halt_o,
    output logic      dec_illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [6:0] shift_f7;
    imm_t       imm_i, imm_s, imm_b, imm_u, imm_j;

    imm_t      imm;
    alu_op_e   alu_op;
    logic      word_op;
    src1_sel_e src1;
    src2_sel_e src2;
    logic      write_gpr, mem_read, mem_write, mem_unsigned;
    mem_size_e mem_size;
    cmp_e      cmp;
    jump_e     jump;
    logic      halt, illegal;

    // alu class for the shared op / op-imm funct3 space
    function automatic alu_op_e base_alu_op(input logic [2:0] f3);
        case (f3)
            F3_ADD_SUB: return alu_add;
            F3_SLL:     return alu_sll;
            F3_SLT:     return alu_slt;
            F3_SLTU:    return alu_sltu;
            F3_XOR:     return alu_xor;
            F3_SR:      return alu_srl;
            F3_OR:      return alu_or;
            default:    return alu_and;
        endcase
    endfunction

    assign opcode = head_inst_i[6:0];
    assign funct3 = head_inst_i[14:12];
    assign funct7 = head_inst_i[31:25];

    // 64-bit shifts take a 6-bit shamt, so bit 25 belongs to it
    assign shift_f7 = (opcode == OPC_OP_IMM) ? {funct7[6:1], 1'b0} : funct7;

    // ============================================================
    // immediate formats
    // ============================================================
    assign imm_i = {{20{head_inst_i[31]}}, head_inst_i[31:20]};
    assign imm_s = {{20{head_inst_i[31]}}, head_inst_i[31:25], head_inst_i[11:7]};
    assign imm_b = {{20{head_inst_i[31]}}, head_inst_i[7], head_inst_i[30:25],
                    head_inst_i[11:8], 1'b0};
    assign imm_u = {head_inst_i[31:12], 12'b0};
    assign imm_j = {{12{head_inst_i[31]}}, head_inst_i[19:12], head_inst_i[20],
                    head_inst_i[30:21], 1'b0};

    // ============================================================
    // decode
    // ============================================================
    always_comb begin
        imm          = '0;
        alu_op       = alu_pass;
        word_op      = 1'b0;
        src1         = src1_rs1;
        src2         = src2_rs2;
        write_gpr    = 1'b1;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_unsigned = 1'b0;
        mem_size     = mem_byte;
        cmp          = cmp_none;
        jump         = jump_none;
        halt         = 1'b0;
        illegal      = 1'b0;
        case (opcode)
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                word_op = (opcode == OPC_OP_IMM_32);
                src2    = src2_imm;
                imm     = imm_i;
                alu_op  = base_alu_op(funct3);
                if (funct3 == F3_SLL) begin
                    illegal = (shift_f7 != F7_BASE);
                end else if (funct3 == F3_SR) begin
                    if (shift_f7 == F7_ALT) begin
                        alu_op = alu_sra;
                    end else begin
                        illegal = (shift_f7 != F7_BASE);
                    end
                end else if (word_op && funct3 != F3_ADD_SUB) begin
                    illegal = 1'b1;
                end
            end
            OPC_OP, OPC_OP_32: begin
                word_op = (opcode == OPC_OP_32);
                alu_op  = base_alu_op(funct3);
                if (funct7 == F7_ALT && funct3 == F3_ADD_SUB) begin
                    alu_op = alu_sub;
                end else if (funct7 == F7_ALT && funct3 == F3_SR) begin
                    alu_op = alu_sra;
                end else if (funct7 != F7_BASE) begin
                    illegal = 1'b1;
                end
                // word forms only exist for add, sub and shifts
                if (word_op && !(funct3 inside {F3_ADD_SUB, F3_SLL, F3_SR})) begin
                    illegal = 1'b1;
                end
            end
            OPC_LOAD: begin
                alu_op       = alu_add;
                src2         = src2_imm;
                imm          = imm_i;
                mem_read     = 1'b1;
                mem_size     = mem_size_e'(funct3[1:0]);
                mem_unsigned = funct3[2];
                illegal      = (funct3[2] && funct3[1:0] == 2'b11);
            end
            OPC_STORE: begin
                alu_op    = alu_add;
                src2      = src2_imm;
                imm       = imm_s;
                write_gpr = 1'b0;
                mem_write = 1'b1;
                mem_size  = mem_size_e'(funct3[1:0]);
                illegal   = funct3[2];
            end
            OPC_BRANCH: begin
                alu_op    = alu_slt;
                imm       = imm_b;
                write_gpr = 1'b0;
                jump      = jump_pc_imm;
                case (funct3)
                    F3_BEQ: cmp = cmp_eq;
                    F3_BNE: cmp = cmp_ne;
                    F3_BLT: cmp = cmp_lt;
                    F3_BGE: cmp = cmp_ge;
                    F3_BLTU: begin
                        cmp    = cmp_ltu;
                        alu_op = alu_sltu;
                    end
                    F3_BGEU: begin
                        cmp    = cmp_geu;
                        alu_op = alu_sltu;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OPC_JAL: begin
                alu_op = alu_add;
                src1   = src1_pc;
                src2   = src2_four;
                imm    = imm_j;
                jump   = jump_pc_imm;
            end
            OPC_JALR: begin
                // alu makes the link value pc + 4
                alu_op  = alu_add;
                src1    = src1_pc;
                src2    = src2_four;
                imm     = imm_i;
                jump    = jump_rs1_imm;
                illegal = (funct3 != F3_JALR);
            end
            OPC_LUI: begin
                src2 = src2_imm;
                imm  = imm_u;
            end
            OPC_AUIPC: begin
                alu_op = alu_add;
                src1   = src1_pc;
                src2   = src2_imm;
                imm    = imm_u;
            end
            OPC_SYSTEM: begin
                // only ebreak is kept from the system space
                if (funct3 == F3_PRIV && head_inst_i[31:20] == EBREAK_FUNCT12) begin
                    halt      = 1'b1;
                    write_gpr = 1'b0;
                    imm       = imm_i;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase

        // illegal word leaves a neutral bundle
        if (illegal) begin
            imm          = '0;
            alu_op       = alu_pass;
            word_op      = 1'b0;
            src1         = src1_rs1;
            src2         = src2_rs2;
            write_gpr    = 1'b0;
            mem_read     = 1'b0;
            mem_write    = 1'b0;
            mem_unsigned = 1'b0;
            mem_size     = mem_byte;
            cmp          = cmp_none;
            jump         = jump_none;
        end
    end

    // ============================================================
    // output register
    // ============================================================
    // load when empty or drained this cycle
    assign pop_o = !empty_i && (!dec_valid_o || dec_ready_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (pop_o) begin
            dec_valid_o <= 1'b1;
        end else if (dec_ready_i) begin
            dec_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            dec_pc_o           <= head_pc_i;
            dec_rd_o           <= head_inst_i[11:7];
            dec_rs1_o          <= head_inst_i[19:15];
            dec_rs2_o          <= head_inst_i[24:20];
            dec_imm_o          <= imm;
            dec_alu_op_o       <= alu_op;
            dec_word_op_o      <= word_op;
            dec_src1_o         <= src1;
            dec_src2_o         <= src2;
            dec_write_gpr_o    <= write_gpr;
            dec_mem_read_o     <= mem_read;
            dec_mem_write_o    <= mem_write;
            dec_mem_unsigned_o <= mem_unsigned;
            dec_mem_size_o     <= mem_size;
            dec_cmp_o          <= cmp;
            dec_jump_o         <= jump;
            dec_halt_o         <= halt;
            dec_illegal_o      <= illegal;
        end
    end

endmodule

// File: decode_frontend.sv
`timescale 1ns/1ps

module decode_frontend import rv_decode_pkg::*; #(
    parameter pc_t RESET_PC    = '0,
    parameter int  QUEUE_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // instruction bus
    output logic      wb_cyc_o,
    output logic      wb_stb_o,
    output pc_t       wb_adr_o,
    input  logic      wb_ack_i,
    input  inst_t     wb_dat_i,
    // decoded stream
    input  logic      dec_ready_i,
    output logic      dec_valid_o,
    output pc_t       dec_pc_o,
    output reg_idx_t  dec_rd_o,
    output reg_idx_t  dec_rs1_o,
    output reg_idx_t  dec_rs2_o,
    output imm_t      dec_imm_o,
    output alu_op_e   dec_alu_op_o,
    output logic      dec_word_op_o,
    output src1_sel_e dec_src1_o,
    output src2_sel_e dec_src2_o,
    output logic      dec_write_gpr_o,
    output logic      dec_mem_read_o,
    output logic      dec_mem_write_o,
    output logic      dec_mem_unsigned_o,
    output mem_size_e dec_mem_size_o,
    output cmp_e      dec_cmp_o,
    output jump_e     dec_jump_o,
    output logic      dec_halt_o,
    output logic      dec_illegal_o
);

    logic  push, pop, full, empty;
    inst_t push_inst, head_inst;
    pc_t   push_pc, head_pc;

    ifetch_wb #(
        .RESET_PC(RESET_PC)
    ) ifetch_wb_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_adr_o    (wb_adr_o),
        .wb_ack_i    (wb_ack_i),
        .wb_dat_i    (wb_dat_i),
        .full_i      (full),
        .push_o      (push),
        .push_inst_o (push_inst),
        .push_pc_o   (push_pc)
    );

    inst_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) inst_queue_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push),
        .push_inst_i (push_inst),
        .push_pc_i   (push_pc),
        .pop_i       (pop),
        .full_o      (full),
        .empty_o     (empty),
        .head_inst_o (head_inst),
        .head_pc_o   (head_pc)
    );

    inst_decoder inst_decoder_i (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .empty_i            (empty),
        .head_inst_i        (head_inst),
        .head_pc_i          (head_pc),
        .pop_o              (pop),
        .dec_ready_i        (dec_ready_i),
        .dec_valid_o        (dec_valid_o),
        .dec_pc_o           (dec_pc_o),
        .dec_rd_o           (dec_rd_o),
        .dec_rs1_o          (dec_rs1_o),
        .dec_rs2_o          (dec_rs2_o),
        .dec_imm_o          (dec_imm_o),
        .dec_alu_op_o       (dec_alu_op_o),
        .dec_word_op_o      (dec_word_op_o),
        .dec_src1_o         (dec_src1_o),
        .dec_src2_o         (dec_src2_o),
        .dec_write_gpr_o    (dec_write_gpr_o),
        .dec_mem_read_o     (dec_mem_read_o),
        .dec_mem_write_o    (dec_mem_write_o),
        .dec_mem_unsigned_o (dec_mem_unsigned_o),
        .dec_mem_size_o     (dec_mem_size_o),
        .dec_cmp_o          (dec_cmp_o),
        .dec_jump_o         (dec_jump_o),
        .dec_halt_o         (dec_halt_o),
        .dec_illegal_o      (dec_illegal_o)
    );

endmodule

// File: decode_frontend_assertions.sv
`timescale 1ns/1ps

module decode_frontend_assertions (
    input logic         clk_i,
    input logic         rst_n_i,
    input logic         wb_cyc_i,
    input logic         wb_stb_i,
    input logic         wb_ack_i,
    input logic [31:0]  wb_adr_i,
    input logic         dec_valid_i,
    input logic         dec_ready_i,
    input logic [99:0]  dec_bundle_i
);

    // ============================================================
    // wishbone master
    // ============================================================
    adr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_stb_i && !wb_ack_i) |=> $stable(wb_adr_i))
        else $error("wishbone address changed before ack");

    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_i |-> wb_cyc_i)
        else $error("wishbone stb high without cyc");

    // ============================================================
    // decoded output handshake
    // ============================================================
    dec_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (dec_valid_i && !dec_ready_i) |=> (dec_valid_i && $stable(dec_bundle_i)))
        else $error("decoded output changed while stalled");

    reset_idle: assert property (@(posedge clk_i) !rst_n_i |=> !dec_valid_i)
        else $error("decoded output valid during reset");

endmodule

bind decode_frontend decode_frontend_assertions decode_frontend_assertions_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .wb_cyc_i     (wb_cyc_o),
    .wb_stb_i     (wb_stb_o),
    .wb_ack_i     (wb_ack_i),
    .wb_adr_i     (wb_adr_o),
    .dec_valid_i  (dec_valid_o),
    .dec_ready_i  (dec_ready_i),
    .dec_bundle_i ({dec_pc_o, dec_rd_o, dec_rs1_o, dec_rs2_o, dec_imm_o, dec_alu_op_o,
                    dec_word_op_o, dec_src1_o, dec_src2_o, dec_write_gpr_o,
                    dec_mem_read_o, dec_mem_write_o, dec_mem_unsigned_o,
                    dec_mem_size_o, dec_cmp_o, dec_jump_o, dec_halt_o, dec_illegal_o})
);

// File: tb_decode_frontend.sv
`timescale 1ns/1ps

module tb_decode_frontend import rv_decode_pkg::*;;

    localparam pc_t RESET_PC       = 32'h0000_0100;
    localparam int  N_ROWS         = 26;
    localparam int  TIMEOUT_CYCLES = N_ROWS * 40;
    localparam logic [31:0] SEED   = 32'hdb5e;

    typedef struct packed {
        inst_t     inst;
        imm_t      imm;
        alu_op_e   alu;
        logic      word;
        src1_sel_e src1;
        src2_sel_e src2;
        logic      wgpr;
        logic      mem_rd;
        logic      mem_wr;
        logic      mem_uns;
        mem_size_e size;
        cmp_e      cmp;
        jump_e     jump;
        logic      halt;
        logic      illegal;
    } row_t;

    logic      clk_i, rst_n_i;
    logic      wb_cyc_o, wb_stb_o, wb_ack_i;
    pc_t       wb_adr_o;
    inst_t     wb_dat_i;
    logic      dec_ready_i, dec_valid_o;
    pc_t       dec_pc_o;
    reg_idx_t  dec_rd_o, dec_rs1_o, dec_rs2_o;
    imm_t      dec_imm_o;
    alu_op_e   dec_alu_op_o;
    logic      dec_word_op_o;
    src1_sel_e dec_src1_o;
    src2_sel_e dec_src2_o;
    logic      dec_write_gpr_o, dec_mem_read_o, dec_mem_write_o, dec_mem_unsigned_o;
    mem_size_e dec_mem_size_o;
    cmp_e      dec_cmp_o;
    jump_e     dec_jump_o;
    logic      dec_halt_o, dec_illegal_o;

    row_t        rows[$];
    logic [31:0] rng_state = SEED;
    logic        in_flight = 1'b0;
    logic [1:0]  wait_left = 2'd0;

    decode_frontend #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (4)
    ) decode_frontend_i (.*);

    // ============================================================
    // table helpers
    // ============================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // neutral bundle, every row starts here
    function automatic row_t blank_row(input inst_t inst, input imm_t imm);
        row_t r;
        r      = '0;
        r.inst = inst;
        r.imm  = imm;
        r.alu  = alu_pass;
        r.src1 = src1_rs1;
        r.src2 = src2_rs2;
        r.size = mem_byte;
        r.cmp  = cmp_none;
        r.jump = jump_none;
        return r;
    endfunction

    task automatic add_alu_row(input inst_t inst, input imm_t imm, input alu_op_e op,
                               input logic word, input src2_sel_e src2);
        row_t r;
        r      = blank_row(inst, imm);
        r.alu  = op;
        r.word = word;
        r.src2 = src2;
        r.wgpr = 1'b1;
        rows.push_back(r);
    endtask

    task automatic add_mem_row(input inst_t inst, input imm_t imm, input logic store,
                               input mem_size_e size, input logic uns);
        row_t r;
        r         = blank_row(inst, imm);
        r.alu     = alu_add;
        r.src2    = src2_imm;
        r.wgpr    = !store;
        r.mem_rd  = !store;
        r.mem_wr  = store;
        r.size    = size;
        r.mem_uns = uns;
        rows.push_back(r);
    endtask

    task automatic add_branch_row(input inst_t inst, input imm_t imm, input cmp_e cmp,
                                  input alu_op_e op);
        row_t r;
        r      = blank_row(inst, imm);
        r.alu  = op;
        r.cmp  = cmp;
        r.jump = jump_pc_imm;
        rows.push_back(r);
    endtask

    // jal, jalr, lui and auipc
    task automatic add_flow_row(input inst_t inst, input imm_t imm, input alu_op_e op,
                                input src1_sel_e src1, input src2_sel_e src2,
                                input jump_e jump);
        row_t r;
        r      = blank_row(inst, imm);
        r.alu  = op;
        r.src1 = src1;
        r.src2 = src2;
        r.jump = jump;
        r.wgpr = 1'b1;
        rows.push_back(r);
    endtask

    task automatic add_system_row(input inst_t inst, input imm_t imm, input logic halt,
                                  input logic illegal);
        row_t r;
        r         = blank_row(inst, imm);
        r.halt    = halt;
        r.illegal = illegal;
        rows.push_back(r);
    endtask

    task automatic build_rows();
        // register and immediate alu forms
        add_alu_row(32'h0020_81b3, 32'h0000_0000, alu_add,  1'b0, src2_rs2);
        add_alu_row(32'h4073_02b3, 32'h0000_0000, alu_sub,  1'b0, src2_rs2);
        add_alu_row(32'h40a4_d433, 32'h0000_0000, alu_sra,  1'b0, src2_rs2);
        add_alu_row(32'h00d6_35b3, 32'h0000_0000, alu_sltu, 1'b0, src2_rs2);
        add_alu_row(32'hfff1_0093, 32'hffff_ffff, alu_add,  1'b0, src2_imm);
        add_alu_row(32'h7ff2_c213, 32'h0000_07ff, alu_xor,  1'b0, src2_imm);
        // slli with shamt 33, srai by 3
        add_alu_row(32'h0213_9313, 32'h0000_0021, alu_sll,  1'b0, src2_imm);
        add_alu_row(32'h4035_d513, 32'h0000_0403, alu_sra,  1'b0, src2_imm);
        // word forms
        add_alu_row(32'h0056_861b, 32'h0000_0005, alu_add,  1'b1, src2_imm);
        add_alu_row(32'h4107_873b, 32'h0000_0000, alu_sub,  1'b1, src2_rs2);
        // ld, lbu, lwu, sd, sh
        add_mem_row(32'h0101_3283, 32'h0000_0010, 1'b0, mem_dword, 1'b0);
        add_mem_row(32'hffc3_c303, 32'hffff_fffc, 1'b0, mem_byte,  1'b1);
        add_mem_row(32'h0084_e403, 32'h0000_0008, 1'b0, mem_word,  1'b1);
        add_mem_row(32'h00a5_bc23, 32'h0000_0018, 1'b1, mem_dword, 1'b0);
        add_mem_row(32'hfec6_9f23, 32'hffff_fffe, 1'b1, mem_half,  1'b0);
        // beq +8, bltu -16, bge +2048
        add_branch_row(32'h0020_8463, 32'h0000_0008, cmp_eq,  alu_slt);
        add_branch_row(32'hfe41_e8e3, 32'hffff_fff0, cmp_ltu, alu_sltu);
        add_branch_row(32'h0062_d0e3, 32'h0000_0800, cmp_ge,  alu_slt);
        add_flow_row(32'h3441_20ef, 32'h0001_2344, alu_add,  src1_pc,  src2_four, jump_pc_imm);
        add_flow_row(32'hff82_80e7, 32'hffff_fff8, alu_add,  src1_pc,  src2_four, jump_rs1_imm);
        add_flow_row(32'habcd_e3b7, 32'habcd_e000, alu_pass, src1_rs1, src2_imm,  jump_none);
        add_flow_row(32'h0000_1497, 32'h0000_1000, alu_add,  src1_pc,  src2_imm,  jump_none);
        // ebreak, then ecall, mul and an all-ones word
        add_system_row(32'h0010_0073, 32'h0000_0001, 1'b1, 1'b0);
        add_system_row(32'h0000_0073, 32'h0000_0000, 1'b0, 1'b1);
        add_system_row(32'h0220_8133, 32'h0000_0000, 1'b0, 1'b1);
        add_system_row(32'hffff_ffff, 32'h0000_0000, 1'b0, 1'b1);
    endtask

    // table words at the bottom, address-based filler above them
    function automatic inst_t bus_read_word(input pc_t adr);
        pc_t offset;
        int  idx;
        offset = adr - RESET_PC;
        idx    = int'(offset >> 2);
        if (adr >= RESET_PC && idx < N_ROWS) begin
            return rows[idx].inst;
        end
        return adr ^ 32'h5a5a_a5a5;
    endfunction

    // ============================================================
    // checks
    // ============================================================
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_row(input int i);
        row_t r;
        r = rows[i];
        check_value("dec_pc_o", dec_pc_o, RESET_PC + pc_t'(4 * i));
        check_value("dec_rd_o", 32'(dec_rd_o), 32'(r.inst[11:7]));
        check_value("dec_rs1_o", 32'(dec_rs1_o), 32'(r.inst[19:15]));
        check_value("dec_rs2_o", 32'(dec_rs2_o), 32'(r.inst[24:20]));
        check_value("dec_imm_o", dec_imm_o, r.imm);
        check_value("dec_alu_op_o", 32'(dec_alu_op_o), 32'(r.alu));
        check_value("dec_word_op_o", 32'(dec_word_op_o), 32'(r.word));
        check_value("dec_src1_o", 32'(dec_src1_o), 32'(r.src1));
        check_value("dec_src2_o", 32'(dec_src2_o), 32'(r.src2));
        check_value("dec_write_gpr_o", 32'(dec_write_gpr_o), 32'(r.wgpr));
        check_value("dec_mem_read_o", 32'(dec_mem_read_o), 32'(r.mem_rd));
        check_value("dec_mem_write_o", 32'(dec_mem_write_o), 32'(r.mem_wr));
        check_value("dec_mem_unsigned_o", 32'(dec_mem_unsigned_o), 32'(r.mem_uns));
        check_value("dec_mem_size_o", 32'(dec_mem_size_o), 32'(r.size));
        check_value("dec_cmp_o", 32'(dec_cmp_o), 32'(r.cmp));
        check_value("dec_jump_o", 32'(dec_jump_o), 32'(r.jump));
        check_value("dec_halt_o", 32'(dec_halt_o), 32'(r.halt));
        check_value("dec_illegal_o", 32'(dec_illegal_o), 32'(r.illegal));
    endtask

    // ============================================================
    // clock, bus slave, ready, watchdog
    // ============================================================
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // one stream of random numbers for both bus waits and ready
    initial begin
        wb_ack_i    = 1'b0;
        wb_dat_i    = '0;
        dec_ready_i = 1'b0;
        @(posedge rst_n_i);
        forever begin
            @(posedge clk_i);
            #1;
            rng_state   = xorshift32(rng_state);
            // ready is rare, so the queue fills and the fetch stalls
            dec_ready_i = (rng_state[2:0] == 3'd0);
            if (wb_ack_i) begin
                wb_ack_i  = 1'b0;
                in_flight = 1'b0;
            end else if (wb_cyc_o && wb_stb_o) begin
                if (!in_flight) begin
                    in_flight = 1'b1;
                    rng_state = xorshift32(rng_state);
                    wait_left = rng_state[1:0];
                end
                if (wait_left == 2'd0) begin
                    wb_ack_i = 1'b1;
                    wb_dat_i = bus_read_word(wb_adr_o);
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("=== FAIL ===");
        $fatal(1, "timeout: the decoded stream did not reach the last table row");
    end

    initial begin
        rst_n_i = 1'b0;
        build_rows();
        if (rows.size() != N_ROWS) begin
            $display("=== FAIL ===");
            $fatal(1, "instruction table holds %0d rows instead of %0d", rows.size(), N_ROWS);
        end
        repeat (5) @(posedge clk_i);
        #1 rst_n_i = 1'b1;
        // valid and ready are settled by the falling edge
        for (int i = 0; i < N_ROWS; i++) begin
            do begin
                @(negedge clk_i);
            end while (!(dec_valid_o && dec_ready_i));
            check_row(i);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: compile.f
rv_decode_pkg.sv
ifetch_wb.sv
inst_queue.sv
inst_decoder.sv
decode_frontend.sv
decode_frontend_assertions.sv
tb_decode_frontend.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the decode front end testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_decode_frontend \
    -f compile.f \
    -o tb_decode_frontend

./obj_dir/tb_decode_frontend
